//--- Bender.yml
package:
  name: axil_mem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/bedrock_lite_pkg.sv
      - rtl/axil_req_capture.sv
      - rtl/mem_fwd_encode.sv
      - rtl/scratch_mem.sv
      - rtl/axil_resp_return.sv
      - rtl/axil_mem_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/axil_mem_asserts.sv
      - bench/tb_axil_mem_top.sv

//--- bench/axil_mem_asserts.sv
`timescale 1ns/1ps

`include "axil_bridge_config.svh"

module axil_mem_asserts (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    awvalid_i,
  input logic                    awready_i,
  input logic                    wvalid_i,
  input logic                    wready_i,
  input logic                    arvalid_i,
  input logic                    arready_i,
  input logic [1:0]              bresp_i,
  input logic                    bvalid_i,
  input logic                    bready_i,
  input logic [`AXIL_DATA_W-1:0] rdata_i,
  input logic [1:0]              rresp_i,
  input logic                    rvalid_i,
  input logic                    rready_i
);

  int unsigned fail_cnt = 0;
  logic [3:0]  inflight_q;
  logic        req_hs;

  assign req_hs = (awvalid_i & awready_i) | (arvalid_i & arready_i);

  // Requests taken but not yet answered
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      inflight_q <= '0;
    end else begin
      inflight_q <= inflight_q + 4'(req_hs) - 4'(bvalid_i & bready_i) - 4'(rvalid_i & rready_i);
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i)
      (!rst_n_i || $rose(rst_n_i)) |->
      !(awready_i || wready_i || arready_i || bvalid_i || rvalid_i))
    else begin
      $error("Ready or response valid high during or right after reset");
      fail_cnt++;
    end

  a_write_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (awvalid_i && wvalid_i) |-> !arready_i)
    else begin
      $error("Read accepted while a complete write was pending");
      fail_cnt++;
    end

  a_aw_w_paired: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      awready_i == wready_i)
    else begin
      $error("AW and W ready differ, write taken by halves");
      fail_cnt++;
    end

  // Empty pipeline means four cycles to the response
  a_wr_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (awvalid_i && awready_i && inflight_q == 0) |=> !bvalid_i [*3] ##1 bvalid_i)
    else begin
      $error("Write response did not rise four cycles after the handshake");
      fail_cnt++;
    end

  a_rd_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (arvalid_i && arready_i && inflight_q == 0) |=> !rvalid_i [*3] ##1 rvalid_i)
    else begin
      $error("Read data did not rise four cycles after the handshake");
      fail_cnt++;
    end

  a_b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (bvalid_i && !bready_i) |=> bvalid_i && $stable(bresp_i))
    else begin
      $error("Write response dropped or changed before its handshake");
      fail_cnt++;
    end

  a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (rvalid_i && !rready_i) |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else begin
      $error("Read data dropped or changed before its handshake");
      fail_cnt++;
    end

  a_resp_okay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (bvalid_i |-> bresp_i == 2'b00) and (rvalid_i |-> rresp_i == 2'b00))
    else begin
      $error("Response code is not OKAY");
      fail_cnt++;
    end

endmodule

//--- bench/tb_axil_mem_top.sv
`timescale 1ns/1ps

`include "axil_bridge_config.svh"

module tb_axil_mem_top;

  localparam int unsigned SEED = 32'h26755e63;
  localparam int RAND_OPS = 300;
  // Tests need about 1500 cycles
  localparam int CYCLE_LIMIT = 4000;

  logic                    clk;
  logic                    rst_n;
  logic [`AXIL_ADDR_W-1:0] awaddr;
  logic [2:0]              awprot;
  logic                    awvalid;
  logic                    awready;
  logic [`AXIL_DATA_W-1:0] wdata;
  logic [`AXIL_STRB_W-1:0] wstrb;
  logic                    wvalid;
  logic                    wready;
  logic [1:0]              bresp;
  logic                    bvalid;
  logic                    bready = 1'b1;
  logic [`AXIL_ADDR_W-1:0] araddr;
  logic [2:0]              arprot;
  logic                    arvalid;
  logic                    arready;
  logic [`AXIL_DATA_W-1:0] rdata;
  logic [1:0]              rresp;
  logic                    rvalid;
  logic                    rready = 1'b1;

  logic [7:0]              model_mem [512];
  logic [`AXIL_DATA_W-1:0] exp_rdata_q [$];
  string                   exp_name_q [$];
  string                   test_name;
  logic                    toggle_ready;
  int                      err_cnt;
  int                      assert_cnt;
  int                      b_expected;
  int                      b_seen;
  int                      cycle_cnt;

  axil_mem_top axil_mem_top_i (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awprot_i  (awprot),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arprot_i  (arprot),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  bind axil_mem_top axil_mem_asserts asserts_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .awvalid_i (s_axil_awvalid_i),
    .awready_i (s_axil_awready_o),
    .wvalid_i  (s_axil_wvalid_i),
    .wready_i  (s_axil_wready_o),
    .arvalid_i (s_axil_arvalid_i),
    .arready_i (s_axil_arready_o),
    .bresp_i   (s_axil_bresp_o),
    .bvalid_i  (s_axil_bvalid_o),
    .bready_i  (s_axil_bready_i),
    .rdata_i   (s_axil_rdata_o),
    .rresp_i   (s_axil_rresp_o),
    .rvalid_i  (s_axil_rvalid_o),
    .rready_i  (s_axil_rready_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Bytes covered by a strobe, patterns outside the table cover the word
  function automatic int strobe_bytes(input logic [7:0] strb);
    int n;
    n = 8;
    if ($countones(strb) == 1) begin
      n = 1;
    end else if (strb == 8'h0F || strb == 8'hF0) begin
      n = 4;
    end else begin
      for (int k = 0; k < 4; k++) begin
        if (strb == (8'h03 << (2 * k))) begin
          n = 2;
        end
      end
    end
    return n;
  endfunction

  // Bytes start at the offset rounded down to the access size
  function automatic void model_write(input logic [31:0] addr, input logic [63:0] data,
                                      input logic [7:0] strb);
    int n;
    int first;
    n = strobe_bytes(strb);
    first = (int'(addr[2:0]) / n) * n;
    for (int k = first; k < first + n; k++) begin
      model_mem[{addr[8:3], 3'(k)}] = data[8*k +: 8];
    end
  endfunction

  function automatic logic [63:0] model_read(input logic [31:0] addr);
    logic [63:0] word;
    for (int k = 0; k < 8; k++) begin
      word[8*k +: 8] = model_mem[{addr[8:3], 3'(k)}];
    end
    return word;
  endfunction

  // Called at a falling edge, returns at a falling edge
  task automatic axil_write(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb);
    awaddr  = addr;
    awprot  = 3'($urandom_range(0, 7));
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    do begin
      @(posedge clk);
    end while (!(awready && wready));
    model_write(addr, data, strb);
    b_expected++;
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr);
    araddr  = addr;
    arprot  = 3'($urandom_range(0, 7));
    arvalid = 1'b1;
    do begin
      @(posedge clk);
    end while (!arready);
    exp_rdata_q.push_back(model_read(addr));
    exp_name_q.push_back(test_name);
    @(negedge clk);
    arvalid = 1'b0;
  endtask

  // Write and read offered in the same cycle
  task automatic write_read_pair(input logic [31:0] waddr, input logic [63:0] data,
                                 input logic [7:0] strb, input logic [31:0] raddr);
    awaddr  = waddr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    araddr  = raddr;
    arvalid = 1'b1;
    do begin
      @(posedge clk);
      if (arready) begin
        err_cnt++;
        $display("Read handshake in %s came before the pending write", test_name);
      end
    end while (!(awready && wready));
    model_write(waddr, data, strb);
    b_expected++;
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    do begin
      @(posedge clk);
    end while (!arready);
    exp_rdata_q.push_back(model_read(raddr));
    exp_name_q.push_back(test_name);
    @(negedge clk);
    arvalid = 1'b0;
  endtask

  task automatic random_op();
    logic [31:0] addr;
    logic [7:0]  strb;
    int          lane;
    addr = ($urandom & 32'hFFFF_FE00) | ($urandom_range(0, 7) << 3) | $urandom_range(0, 7);
    lane = $urandom_range(0, 3);
    case ($urandom_range(0, 4))
      0:       strb = 8'h01 << $urandom_range(0, 7);
      1:       strb = 8'h03 << (2 * lane);
      2:       strb = lane[0] ? 8'hF0 : 8'h0F;
      3:       strb = 8'($urandom);
      default: strb = 8'hFF;
    endcase
    if ($urandom_range(0, 1) == 1) begin
      axil_read(addr);
    end else begin
      axil_write(addr, {$urandom, $urandom}, strb);
    end
  endtask

  task automatic wait_idle();
    while (exp_rdata_q.size() != 0 || b_seen != b_expected) begin
      @(negedge clk);
    end
  endtask

  always @(negedge clk) begin
    if (toggle_ready) begin
      bready = 1'($urandom_range(0, 1));
      rready = 1'($urandom_range(0, 1));
    end else begin
      bready = 1'b1;
      rready = 1'b1;
    end
  end

  // Response checker, B and R are ordered within their own channel
  always @(posedge clk) begin
    if (rst_n && bvalid && bready) begin
      if (b_seen >= b_expected) begin
        err_cnt++;
        $display("Write response arrived with no write outstanding");
      end
      b_seen++;
    end
    if (rst_n && rvalid && rready) begin
      if (exp_rdata_q.size() == 0) begin
        err_cnt++;
        $display("Read data arrived with no read outstanding");
      end else begin
        if (rdata !== exp_rdata_q[0]) begin
          err_cnt++;
          $display("Mismatch in %s: expected %h, actual %h", exp_name_q[0],
                   exp_rdata_q[0], rdata);
        end
        void'(exp_rdata_q.pop_front());
        void'(exp_name_q.pop_front());
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles with responses still missing", CYCLE_LIMIT);
    $display("Errors: %0d check, %0d assertion", err_cnt, axil_mem_top_i.asserts_i.fail_cnt);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    err_cnt      = 0;
    b_expected   = 0;
    b_seen       = 0;
    toggle_ready = 1'b0;
    rst_n        = 1'b0;
    awaddr       = '0;
    awprot       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    araddr       = '0;
    arprot       = '0;
    arvalid      = 1'b0;
    test_name    = "reset";
    for (int i = 0; i < 512; i++) begin
      model_mem[i] = 8'h00;
    end
    // Requests offered across reset and the first cycle after it
    @(negedge clk);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    arvalid = 1'b1;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    @(negedge clk);

    test_name = "full_word";
    axil_write(32'h0000_0040, 64'h0123_4567_89AB_CDEF, 8'hFF);
    wait_idle();
    axil_read(32'h0000_0040);
    wait_idle();

    // Lanes from the size table at matching offsets
    test_name = "partial_strobe";
    axil_write(32'h0000_0080, 64'h0011_2233_4455_6677, 8'hFF);
    axil_write(32'h0000_0082, {$urandom, $urandom}, 8'h04);
    axil_read(32'h0000_0080);
    axil_write(32'h0000_0084, {$urandom, $urandom}, 8'h30);
    axil_read(32'h0000_0080);
    axil_write(32'h0000_0086, {$urandom, $urandom}, 8'hC0);
    axil_read(32'h0000_0080);
    axil_write(32'h0000_0087, {$urandom, $urandom}, 8'h80);
    axil_read(32'h0000_0080);
    axil_write(32'h0000_0084, {$urandom, $urandom}, 8'hF0);
    axil_read(32'h0000_0080);
    axil_write(32'h0000_0080, {$urandom, $urandom}, 8'h0F);
    axil_read(32'h0000_0080);
    wait_idle();

    test_name = "out_of_table";
    axil_write(32'h0000_00C0, 64'hFFFF_FFFF_FFFF_FFFF, 8'hFF);
    axil_write(32'h0000_00C0, {$urandom, $urandom}, 8'h05);
    axil_read(32'h0000_00C0);
    wait_idle();

    // One request in flight at a time
    test_name = "latency";
    for (int i = 0; i < 4; i++) begin
      axil_write(32'h0000_0100 + 32'(8 * i), {$urandom, $urandom}, 8'hFF);
      wait_idle();
      axil_read(32'h0000_0100 + 32'(8 * i));
      wait_idle();
    end

    test_name = "write_first";
    write_read_pair(32'h0000_0140, {$urandom, $urandom}, 8'hFF, 32'h0000_0140);
    wait_idle();

    test_name = "random";
    toggle_ready = 1'b1;
    repeat (RAND_OPS) begin
      random_op();
    end
    toggle_ready = 1'b0;
    wait_idle();

    assert_cnt = axil_mem_top_i.asserts_i.fail_cnt;
    $display("Errors: %0d check, %0d assertion", err_cnt, assert_cnt);
    if (err_cnt == 0 && assert_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- rtl/axil_bridge_config.svh
`ifndef AXIL_BRIDGE_CONFIG_SVH
`define AXIL_BRIDGE_CONFIG_SVH

// AXI4-Lite data word, one 64-bit beat
`define AXIL_DATA_W 64

// Byte address on the AXI4-Lite side
`define AXIL_ADDR_W 32

// One strobe bit per data byte
`define AXIL_STRB_W 8

// Scratchpad depth in 64-bit words, log2
`define MEM_WORDS_LG 6

// Message size code, log2 of the byte count
`define MSG_SIZE_W 2

`endif

//--- rtl/axil_mem_top.sv
`timescale 1ns/1ps

`include "axil_bridge_config.svh"

module axil_mem_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  input  logic [`AXIL_ADDR_W-1:0] s_axil_awaddr_i,
  input  logic [2:0]              s_axil_awprot_i,
  input  logic                    s_axil_awvalid_i,
  output logic                    s_axil_awready_o,

  input  logic [`AXIL_DATA_W-1:0] s_axil_wdata_i,
  input  logic [`AXIL_STRB_W-1:0] s_axil_wstrb_i,
  input  logic                    s_axil_wvalid_i,
  output logic                    s_axil_wready_o,

  output logic [1:0]              s_axil_bresp_o,
  output logic                    s_axil_bvalid_o,
  input  logic                    s_axil_bready_i,

  input  logic [`AXIL_ADDR_W-1:0] s_axil_araddr_i,
  input  logic [2:0]              s_axil_arprot_i,
  input  logic                    s_axil_arvalid_i,
  output logic                    s_axil_arready_o,

  output logic [`AXIL_DATA_W-1:0] s_axil_rdata_o,
  output logic [1:0]              s_axil_rresp_o,
  output logic                    s_axil_rvalid_o,
  input  logic                    s_axil_rready_i
);

  // Capture to encode
  logic                        req_v;
  logic                        req_ready_and;
  logic                        req_w;
  logic [`AXIL_ADDR_W-1:0]     req_addr;
  logic [`AXIL_DATA_W-1:0]     req_data;
  logic [`AXIL_STRB_W-1:0]     req_mask;

  // Encode to scratchpad
  logic                        fwd_v;
  logic                        fwd_ready_and;
  bedrock_lite_pkg::msg_type_e fwd_type;
  bedrock_lite_pkg::msg_size_e fwd_size;
  logic [`AXIL_ADDR_W-1:0]     fwd_addr;
  logic [`AXIL_DATA_W-1:0]     fwd_data;

  // Scratchpad to return
  logic                        rev_v;
  logic                        rev_ready_and;
  bedrock_lite_pkg::msg_type_e rev_type;
  logic [`AXIL_DATA_W-1:0]     rev_data;

  axil_req_capture capture_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awprot_i  (s_axil_awprot_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arprot_i  (s_axil_arprot_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .req_v_o          (req_v),
    .req_w_o          (req_w),
    .req_addr_o       (req_addr),
    .req_data_o       (req_data),
    .req_mask_o       (req_mask),
    .req_ready_and_i  (req_ready_and)
  );

  mem_fwd_encode encode_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_v_i         (req_v),
    .req_w_i         (req_w),
    .req_addr_i      (req_addr),
    .req_data_i      (req_data),
    .req_mask_i      (req_mask),
    .req_ready_and_o (req_ready_and),
    .fwd_v_o         (fwd_v),
    .fwd_type_o      (fwd_type),
    .fwd_size_o      (fwd_size),
    .fwd_addr_o      (fwd_addr),
    .fwd_data_o      (fwd_data),
    .fwd_ready_and_i (fwd_ready_and)
  );

  scratch_mem scratch_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fwd_v_i         (fwd_v),
    .fwd_type_i      (fwd_type),
    .fwd_size_i      (fwd_size),
    .fwd_addr_i      (fwd_addr),
    .fwd_data_i      (fwd_data),
    .fwd_ready_and_o (fwd_ready_and),
    .rev_v_o         (rev_v),
    .rev_type_o      (rev_type),
    .rev_data_o      (rev_data),
    .rev_ready_and_i (rev_ready_and)
  );

  axil_resp_return return_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .rev_v_i         (rev_v),
    .rev_type_i      (rev_type),
    .rev_data_i      (rev_data),
    .rev_ready_and_o (rev_ready_and),
    .s_axil_bresp_o  (s_axil_bresp_o),
    .s_axil_bvalid_o (s_axil_bvalid_o),
    .s_axil_bready_i (s_axil_bready_i),
    .s_axil_rdata_o  (s_axil_rdata_o),
    .s_axil_rresp_o  (s_axil_rresp_o),
    .s_axil_rvalid_o (s_axil_rvalid_o),
    .s_axil_rready_i (s_axil_rready_i)
  );

endmodule

//--- rtl/axil_req_capture.sv
`timescale 1ns/1ps

`include "axil_bridge_config.svh"

module axil_req_capture (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  input  logic [`AXIL_ADDR_W-1:0] s_axil_awaddr_i,
  input  logic [2:0]              s_axil_awprot_i,
  input  logic                    s_axil_awvalid_i,
  output logic                    s_axil_awready_o,

  input  logic [`AXIL_DATA_W-1:0] s_axil_wdata_i,
  input  logic [`AXIL_STRB_W-1:0] s_axil_wstrb_i,
  input  logic                    s_axil_wvalid_i,
  output logic                    s_axil_wready_o,

  input  logic [`AXIL_ADDR_W-1:0] s_axil_araddr_i,
  input  logic [2:0]              s_axil_arprot_i,
  input  logic                    s_axil_arvalid_i,
  output logic                    s_axil_arready_o,

  output logic                    req_v_o,
  output logic                    req_w_o,
  output logic [`AXIL_ADDR_W-1:0] req_addr_o,
  output logic [`AXIL_DATA_W-1:0] req_data_o,
  output logic [`AXIL_STRB_W-1:0] req_mask_o,
  input  logic                    req_ready_and_i
);

  logic                    live_q;
  logic                    req_v_q;
  logic                    req_w_q;
  logic [`AXIL_ADDR_W-1:0] req_addr_q;
  logic [`AXIL_DATA_W-1:0] req_data_q;
  logic [`AXIL_STRB_W-1:0] req_mask_q;
  logic                    slot_free;
  logic                    wr_pend;
  logic                    wr_take;
  logic                    rd_take;

  // Slot can load when empty or when its request leaves this cycle
  assign slot_free = live_q & (~req_v_q | req_ready_and_i);

  // AW and W only go together, never half a write
  assign wr_pend = s_axil_awvalid_i & s_axil_wvalid_i;
  assign wr_take = slot_free & wr_pend;
  assign rd_take = slot_free & s_axil_arvalid_i & ~wr_pend;

  assign s_axil_awready_o = wr_take;
  assign s_axil_wready_o  = wr_take;
  assign s_axil_arready_o = rd_take;

  // Protection bits are ignored

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      live_q  <= 1'b0;
      req_v_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (wr_take || rd_take) begin
        req_v_q <= 1'b1;
      end else if (req_ready_and_i) begin
        req_v_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_take) begin
      req_w_q    <= 1'b1;
      req_addr_q <= s_axil_awaddr_i;
      req_data_q <= s_axil_wdata_i;
      req_mask_q <= s_axil_wstrb_i;
    end else if (rd_take) begin
      req_w_q    <= 1'b0;
      req_addr_q <= s_axil_araddr_i;
      req_data_q <= '0;
      // Reads cover the full word
      req_mask_q <= '1;
    end
  end

  assign req_v_o    = req_v_q;
  assign req_w_o    = req_w_q;
  assign req_addr_o = req_addr_q;
  assign req_data_o = req_data_q;
  assign req_mask_o = req_mask_q;

endmodule

//--- rtl/axil_resp_return.sv
`timescale 1ns/1ps

`include "axil_bridge_config.svh"

module axil_resp_return (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic                        rev_v_i,
  input  bedrock_lite_pkg::msg_type_e rev_type_i,
  input  logic [`AXIL_DATA_W-1:0]     rev_data_i,
  output logic                        rev_ready_and_o,

  output logic [1:0]                  s_axil_bresp_o,
  output logic                        s_axil_bvalid_o,
  input  logic                        s_axil_bready_i,

  output logic [`AXIL_DATA_W-1:0]     s_axil_rdata_o,
  output logic [1:0]                  s_axil_rresp_o,
  output logic                        s_axil_rvalid_o,
  input  logic                        s_axil_rready_i
);

  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic                    bvalid_q;
  logic                    rvalid_q;
  logic [`AXIL_DATA_W-1:0] rdata_q;
  logic                    is_rd;
  logic                    rev_take;

  assign is_rd = (rev_type_i == bedrock_lite_pkg::e_mem_rd);

  // Target slot must be empty or draining
  assign rev_ready_and_o = is_rd ? (~rvalid_q | s_axil_rready_i)
                                 : (~bvalid_q | s_axil_bready_i);
  assign rev_take = rev_v_i & rev_ready_and_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (rev_take && !is_rd) begin
        bvalid_q <= 1'b1;
      end else if (s_axil_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rev_take && is_rd) begin
        rvalid_q <= 1'b1;
      end else if (s_axil_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rev_take && is_rd) begin
      rdata_q <= rev_data_i;
    end
  end

  // No error responses
  assign s_axil_bresp_o  = RESP_OKAY;
  assign s_axil_rresp_o  = RESP_OKAY;
  assign s_axil_bvalid_o = bvalid_q;
  assign s_axil_rvalid_o = rvalid_q;
  assign s_axil_rdata_o  = rdata_q;

endmodule

//--- rtl/bedrock_lite_pkg.sv
`include "axil_bridge_config.svh"

package bedrock_lite_pkg;

  // Forward and reverse message types
  typedef enum logic [1:0] {
    e_mem_rd = 2'b00,
    e_mem_wr = 2'b01
  } msg_type_e;

  // Size code is log2 of the byte count
  typedef enum logic [`MSG_SIZE_W-1:0] {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2,
    e_size_8 = 2'd3
  } msg_size_e;

endpackage

//--- rtl/mem_fwd_encode.sv
`timescale 1ns/1ps

`include "axil_bridge_config.svh"

module mem_fwd_encode (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic                        req_v_i,
  input  logic                        req_w_i,
  input  logic [`AXIL_ADDR_W-1:0]     req_addr_i,
  input  logic [`AXIL_DATA_W-1:0]     req_data_i,
  input  logic [`AXIL_STRB_W-1:0]     req_mask_i,
  output logic                        req_ready_and_o,

  output logic                        fwd_v_o,
  output bedrock_lite_pkg::msg_type_e fwd_type_o,
  output bedrock_lite_pkg::msg_size_e fwd_size_o,
  output logic [`AXIL_ADDR_W-1:0]     fwd_addr_o,
  output logic [`AXIL_DATA_W-1:0]     fwd_data_o,
  input  logic                        fwd_ready_and_i
);

  logic                        fwd_v_q;
  bedrock_lite_pkg::msg_type_e fwd_type_q;
  bedrock_lite_pkg::msg_size_e fwd_size_q;
  logic [`AXIL_ADDR_W-1:0]     fwd_addr_q;
  logic [`AXIL_DATA_W-1:0]     fwd_data_q;
  bedrock_lite_pkg::msg_size_e size_d;
  logic                        req_take;

  // Strobe to size table, unknown patterns become a full write
  function automatic bedrock_lite_pkg::msg_size_e strb_to_size(
    input logic [`AXIL_STRB_W-1:0] strb
  );
    case (strb)
      8'h01, 8'h02, 8'h04, 8'h08,
      8'h10, 8'h20, 8'h40, 8'h80: strb_to_size = bedrock_lite_pkg::e_size_1;
      8'h03, 8'h0C, 8'h30, 8'hC0: strb_to_size = bedrock_lite_pkg::e_size_2;
      8'h0F, 8'hF0:               strb_to_size = bedrock_lite_pkg::e_size_4;
      default:                    strb_to_size = bedrock_lite_pkg::e_size_8;
    endcase
  endfunction

  assign size_d = req_w_i ? strb_to_size(req_mask_i) : bedrock_lite_pkg::e_size_8;

  assign req_ready_and_o = ~fwd_v_q | fwd_ready_and_i;
  assign req_take        = req_v_i & req_ready_and_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fwd_v_q <= 1'b0;
    end else if (req_take) begin
      fwd_v_q <= 1'b1;
    end else if (fwd_ready_and_i) begin
      fwd_v_q <= 1'b0;
    end
  end

  // Header and data slot
  always_ff @(posedge clk_i) begin
    if (req_take) begin
      fwd_type_q <= req_w_i ? bedrock_lite_pkg::e_mem_wr : bedrock_lite_pkg::e_mem_rd;
      fwd_size_q <= size_d;
      fwd_addr_q <= req_addr_i;
      fwd_data_q <= req_data_i;
    end
  end

  assign fwd_v_o    = fwd_v_q;
  assign fwd_type_o = fwd_type_q;
  assign fwd_size_o = fwd_size_q;
  assign fwd_addr_o = fwd_addr_q;
  assign fwd_data_o = fwd_data_q;

endmodule

//--- rtl/scratch_mem.sv
`timescale 1ns/1ps

`include "axil_bridge_config.svh"

module scratch_mem (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic                        fwd_v_i,
  input  bedrock_lite_pkg::msg_type_e fwd_type_i,
  input  bedrock_lite_pkg::msg_size_e fwd_size_i,
  input  logic [`AXIL_ADDR_W-1:0]     fwd_addr_i,
  input  logic [`AXIL_DATA_W-1:0]     fwd_data_i,
  output logic                        fwd_ready_and_o,

  output logic                        rev_v_o,
  output bedrock_lite_pkg::msg_type_e rev_type_o,
  output logic [`AXIL_DATA_W-1:0]     rev_data_o,
  input  logic                        rev_ready_and_i
);

  localparam int MEM_WORDS = 1 << `MEM_WORDS_LG;

  logic [`AXIL_DATA_W-1:0]     mem_q [MEM_WORDS];
  logic                        rev_v_q;
  bedrock_lite_pkg::msg_type_e rev_type_q;
  logic [`AXIL_DATA_W-1:0]     rev_data_q;
  logic [`MEM_WORDS_LG-1:0]    word_idx;
  logic [2:0]                  byte_off;
  logic [`AXIL_STRB_W-1:0]     byte_mask;
  logic                        fwd_take;
  logic                        wr_en;

  // Word index from bits 8:3, byte offset from 2:0
  assign word_idx = fwd_addr_i[`MEM_WORDS_LG+2:3];
  assign byte_off = fwd_addr_i[2:0];

  // Offset rounded down to the access size
  always_comb begin
    case (fwd_size_i)
      bedrock_lite_pkg::e_size_1: byte_mask = 8'h01 << byte_off;
      bedrock_lite_pkg::e_size_2: byte_mask = 8'h03 << {byte_off[2:1], 1'b0};
      bedrock_lite_pkg::e_size_4: byte_mask = 8'h0F << {byte_off[2], 2'b00};
      default:                    byte_mask = 8'hFF;
    endcase
  end

  assign fwd_ready_and_o = ~rev_v_q | rev_ready_and_i;
  assign fwd_take        = fwd_v_i & fwd_ready_and_o;
  assign wr_en           = fwd_take & (fwd_type_i == bedrock_lite_pkg::e_mem_wr);

  // Storage clears to zero at reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en) begin
      for (int b = 0; b < `AXIL_STRB_W; b++) begin
        if (byte_mask[b]) begin
          mem_q[word_idx][8*b +: 8] <= fwd_data_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rev_v_q <= 1'b0;
    end else if (fwd_take) begin
      rev_v_q <= 1'b1;
    end else if (rev_ready_and_i) begin
      rev_v_q <= 1'b0;
    end
  end

  // Reverse message, old word contents on a read
  always_ff @(posedge clk_i) begin
    if (fwd_take) begin
      rev_type_q <= fwd_type_i;
      rev_data_q <= mem_q[word_idx];
    end
  end

  assign rev_v_o    = rev_v_q;
  assign rev_type_o = rev_type_q;
  assign rev_data_o = rev_data_q;

endmodule

//--- tb.f
+incdir+rtl
rtl/bedrock_lite_pkg.sv
rtl/axil_req_capture.sv
rtl/mem_fwd_encode.sv
rtl/scratch_mem.sv
rtl/axil_resp_return.sv
rtl/axil_mem_top.sv
bench/axil_mem_asserts.sv
bench/tb_axil_mem_top.sv
